// ==== armLite_macros.svh ====
`ifndef ARMLITE_MACROS_SVH
`define ARMLITE_MACROS_SVH

// Word width of the datapath
`define ARM_XLEN 32

// Architectural register count
`define ARM_NREGS 16

// Data memory depth in words
`define ARM_DMEM_WORDS 16

`endif

// ==== armLitePkg.sv ====
`default_nettype none

package armLitePkg;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;   // Rotated immediate operand
    logic [3:0]  opcode;
    logic        setFlags;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;  // rot/imm8 or shift/rm
  } dpView_t;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;   // Register offset when set
    logic        pre;
    logic        up;
    logic        byteFlag;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] imm12;
  } memView_t;

  // One instruction word, two decodings
  typedef union packed {
    dpView_t  dp;
    memView_t mem;
  } armInstr_u;

  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluEor = 4'b0001,
    aluSub = 4'b0010,
    aluRsb = 4'b0011,
    aluAdd = 4'b0100,
    aluAdc = 4'b0101,
    aluSbc = 4'b0110,
    aluTst = 4'b1000,
    aluCmp = 4'b1010,
    aluOrr = 4'b1100,
    aluMov = 4'b1101
  } aluOp_e;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } flags_t;

endpackage

`default_nettype wire

// ==== condUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module condUnit import armLitePkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       stall,
  input  logic       enable,
  input  logic [3:0] cond,
  input  flags_t     aluFlags,
  input  logic [1:0] flagWrite,
  output logic       condEx,
  output flags_t     flags
);

  logic ge;

  assign ge = (flags.neg == flags.overflow);

  always_comb begin
    case (cond)
      4'b0000: condEx = flags.zero;                 // EQ
      4'b0001: condEx = ~flags.zero;                // NE
      4'b0010: condEx = flags.carry;                // CS
      4'b0011: condEx = ~flags.carry;               // CC
      4'b0100: condEx = flags.neg;                  // MI
      4'b0101: condEx = ~flags.neg;                 // PL
      4'b0110: condEx = flags.overflow;             // VS
      4'b0111: condEx = ~flags.overflow;            // VC
      4'b1000: condEx = flags.carry & ~flags.zero;  // HI
      4'b1001: condEx = ~flags.carry | flags.zero;  // LS
      4'b1010: condEx = ge;                         // GE
      4'b1011: condEx = ~ge;                        // LT
      4'b1100: condEx = ~flags.zero & ge;           // GT
      4'b1101: condEx = flags.zero | ~ge;           // LE
      4'b1110: condEx = 1'b1;                       // AL
      4'b1111: condEx = 1'b0;                       // Never
    endcase
  end

  // NZ and CV pairs update independently
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (!stall && enable && condEx) begin
      if (flagWrite[1]) begin
        flags.neg  <= aluFlags.neg;
        flags.zero <= aluFlags.zero;
      end
      if (flagWrite[0]) begin
        flags.carry    <= aluFlags.carry;
        flags.overflow <= aluFlags.overflow;
      end
    end
  end

endmodule

`default_nettype wire

// ==== instrDecode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "armLite_macros.svh"

module instrDecode import armLitePkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 instrValid,
  input  armInstr_u            instr,
  input  logic                 wbValid,
  input  logic [3:0]           wbReg,
  input  logic [`ARM_XLEN-1:0] wbData,
  output logic                 validE,
  output aluOp_e               aluOpE,
  output logic                 aluSrcImmE,
  output logic [1:0]           flagWriteE,
  output logic                 regWriteE,
  output logic                 memWriteE,
  output logic                 memToRegE,
  output logic                 branchE,
  output logic [3:0]           condE,
  output logic [3:0]           rdE,
  output logic [`ARM_XLEN-1:0] srcAE,
  output logic [`ARM_XLEN-1:0] srcBE,
  output logic [`ARM_XLEN-1:0] storeDataE
);

  logic [`ARM_XLEN-1:0] regFile [`ARM_NREGS];
  logic                 regWe;
  logic                 definedD, isTestD, useRegBD;
  aluOp_e               aluOpD;
  logic                 aluSrcImmD, regWriteD, memWriteD, memToRegD, branchD;
  logic [1:0]           flagWriteD;
  logic [3:0]           rdD;
  logic [`ARM_XLEN-1:0] immD;

  assign regWe = wbValid & ~stall;  // Writes are frozen by stall

  // Read port with write-through of the W stage
  function automatic logic [`ARM_XLEN-1:0] readReg(input logic [3:0] idx);
    if (regWe && wbReg == idx) return wbData;
    return regFile[idx];
  endfunction

  always_comb begin
    definedD   = 1'b0;
    isTestD    = 1'b0;
    useRegBD   = 1'b0;
    aluOpD     = aluAdd;  // Address and branch forms add
    aluSrcImmD = 1'b0;
    flagWriteD = 2'b00;
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memToRegD  = 1'b0;
    branchD    = 1'b0;
    rdD        = instr.dp.rd;
    immD       = '0;
    case (instr.dp.op)
      2'b00: begin  // Data processing
        case (instr.dp.opcode)
          aluAnd, aluEor, aluSub, aluRsb, aluAdd, aluAdc, aluSbc,
          aluTst, aluCmp, aluOrr, aluMov: definedD = 1'b1;
          default:                        definedD = 1'b0;
        endcase
        aluOpD     = aluOp_e'(instr.dp.opcode);
        isTestD    = (aluOpD == aluCmp) || (aluOpD == aluTst);
        // Test forms without S are other instructions
        if (isTestD && !instr.dp.setFlags) definedD = 1'b0;
        if (!instr.dp.immFlag && instr.dp.operand2[11:4] != '0) definedD = 1'b0;
        aluSrcImmD = instr.dp.immFlag;
        useRegBD   = ~instr.dp.immFlag;
        immD       = {{(`ARM_XLEN-12){1'b0}}, instr.dp.operand2};
        flagWriteD = {2{instr.dp.setFlags}};
        regWriteD  = ~isTestD;
      end
      2'b01: begin  // LDR and STR, positive offset only
        definedD  = ~instr.mem.immFlag & instr.mem.pre & instr.mem.up &
                    ~instr.mem.byteFlag & ~instr.mem.writeBack;
        regWriteD = instr.mem.load;
        memToRegD = instr.mem.load;
        memWriteD = ~instr.mem.load;
        rdD       = instr.mem.rd;
        immD      = {{(`ARM_XLEN-12){1'b0}}, instr.mem.imm12};
      end
      2'b10: begin  // B, link bit not supported
        definedD = instr.dp.immFlag & ~instr.dp.opcode[3];
        branchD  = 1'b1;
      end
      default: definedD = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ARM_NREGS; i++) regFile[i] <= '0;
    end else if (regWe) begin
      regFile[wbReg] <= wbData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      validE     <= 1'b0;
      flagWriteE <= 2'b00;
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      memToRegE  <= 1'b0;
      branchE    <= 1'b0;
    end else if (!stall) begin
      validE     <= instrValid & definedD;
      flagWriteE <= flagWriteD;
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      memToRegE  <= memToRegD;
      branchE    <= branchD;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      aluOpE     <= aluOpD;
      aluSrcImmE <= aluSrcImmD;
      condE      <= instr.dp.cond;
      rdE        <= rdD;
      srcAE      <= readReg(instr.dp.rn);
      srcBE      <= useRegBD ? readReg(instr.dp.operand2[3:0]) : immD;
      storeDataE <= readReg(instr.mem.rd);  // STR source
    end
  end

endmodule

`default_nettype wire

// ==== aluExec.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "armLite_macros.svh"

module aluExec import armLitePkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 validE,
  input  aluOp_e               aluOpE,
  input  logic                 aluSrcImmE,
  input  logic [1:0]           flagWriteE,
  input  logic                 regWriteE,
  input  logic                 memWriteE,
  input  logic                 memToRegE,
  input  logic                 branchE,
  input  logic [3:0]           condE,
  input  logic [3:0]           rdE,
  input  logic [`ARM_XLEN-1:0] srcAE,
  input  logic [`ARM_XLEN-1:0] srcBE,
  input  logic [`ARM_XLEN-1:0] storeDataE,
  output flags_t               flags,
  output logic                 branchTaken,
  output logic                 validM,
  output logic                 regWriteM,
  output logic                 memWriteM,
  output logic                 memToRegM,
  output logic [3:0]           rdM,
  output logic [`ARM_XLEN-1:0] aluResultM,
  output logic [`ARM_XLEN-1:0] storeDataM
);

  localparam int Msb = `ARM_XLEN - 1;

  logic [2*`ARM_XLEN-1:0] rotWide;
  logic [`ARM_XLEN-1:0]   opB, addA, addB, logicRes, result;
  logic [`ARM_XLEN:0]     sum;
  logic                   carryIn, isArith, shiftCarry, condEx;
  flags_t                 aluFlags;

  // imm8 rotated right by twice the rot field
  assign rotWide    = {2{{(`ARM_XLEN-8){1'b0}}, srcBE[7:0]}} >> {srcBE[11:8], 1'b0};
  assign opB        = aluSrcImmE ? rotWide[Msb:0] : srcBE;
  assign shiftCarry = (aluSrcImmE && srcBE[11:8] != '0) ? opB[Msb] : flags.carry;

  always_comb begin
    addA     = srcAE;
    addB     = opB;
    carryIn  = 1'b0;
    isArith  = 1'b1;
    logicRes = '0;
    case (aluOpE)
      aluSub, aluCmp: begin
        addB    = ~opB;
        carryIn = 1'b1;
      end
      aluRsb: begin
        addA    = opB;
        addB    = ~srcAE;
        carryIn = 1'b1;
      end
      aluAdc: carryIn = flags.carry;
      aluSbc: begin
        addB    = ~opB;
        carryIn = flags.carry;  // Borrow is inverted carry
      end
      aluAnd, aluTst: begin
        isArith  = 1'b0;
        logicRes = srcAE & opB;
      end
      aluEor: begin
        isArith  = 1'b0;
        logicRes = srcAE ^ opB;
      end
      aluOrr: begin
        isArith  = 1'b0;
        logicRes = srcAE | opB;
      end
      aluMov: begin
        isArith  = 1'b0;
        logicRes = opB;
      end
      default: ;  // ADD
    endcase
    sum    = {1'b0, addA} + {1'b0, addB} + {{`ARM_XLEN{1'b0}}, carryIn};
    result = isArith ? sum[Msb:0] : logicRes;
  end

  assign aluFlags.neg      = result[Msb];
  assign aluFlags.zero     = (result == '0);
  assign aluFlags.carry    = isArith ? sum[`ARM_XLEN] : shiftCarry;
  assign aluFlags.overflow = isArith ? ((addA[Msb] == addB[Msb]) && (sum[Msb] != addA[Msb]))
                                     : flags.overflow;  // Logical ops keep V

  condUnit i_condUnit (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .enable   (validE),
    .cond     (condE),
    .aluFlags (aluFlags),
    .flagWrite(flagWriteE),
    .condEx   (condEx),
    .flags    (flags)
  );

  // Pulse only on the cycle the E stage advances
  assign branchTaken = validE & branchE & condEx & ~stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      validM    <= 1'b0;
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end else if (!stall) begin
      validM    <= validE;
      regWriteM <= validE & condEx & regWriteE;
      memWriteM <= validE & condEx & memWriteE;
      memToRegM <= memToRegE;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      rdM        <= rdE;
      aluResultM <= result;
      storeDataM <= storeDataE;
    end
  end

endmodule

`default_nettype wire

// ==== memWriteback.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "armLite_macros.svh"

module memWriteback (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 validM,
  input  logic                 regWriteM,
  input  logic                 memWriteM,
  input  logic                 memToRegM,
  input  logic [3:0]           rdM,
  input  logic [`ARM_XLEN-1:0] aluResultM,
  input  logic [`ARM_XLEN-1:0] storeDataM,
  output logic                 memWe,
  output logic [`ARM_XLEN-1:0] memAddr,
  output logic [`ARM_XLEN-1:0] memData,
  output logic                 wbValid,
  output logic [3:0]           wbReg,
  output logic [`ARM_XLEN-1:0] wbData
);

  logic [`ARM_XLEN-1:0]               dataMem [`ARM_DMEM_WORDS];
  logic [$clog2(`ARM_DMEM_WORDS)-1:0] wordAddr;
  logic [`ARM_XLEN-1:0]               readData;

  assign memWe    = validM & memWriteM;
  assign memAddr  = aluResultM;
  assign memData  = storeDataM;
  assign wordAddr = aluResultM[$clog2(`ARM_DMEM_WORDS)+1:2];  // Word addressed
  assign readData = dataMem[wordAddr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ARM_DMEM_WORDS; i++) dataMem[i] <= '0;
    end else if (memWe && !stall) begin
      dataMem[wordAddr] <= storeDataM;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid <= 1'b0;
    end else if (!stall) begin
      wbValid <= validM & regWriteM;
    end
  end

  // Writeback payload, loaded word for LDR
  always_ff @(posedge clk) begin
    if (!stall) begin
      wbReg  <= rdM;
      wbData <= memToRegM ? readData : aluResultM;
    end
  end

endmodule

`default_nettype wire

// ==== armLiteCore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "armLite_macros.svh"

module armLiteCore import armLitePkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 instrValid,
  input  armInstr_u            instr,
  output logic                 wbValid,
  output logic [3:0]           wbReg,
  output logic [`ARM_XLEN-1:0] wbData,
  output logic                 memWe,
  output logic [`ARM_XLEN-1:0] memAddr,
  output logic [`ARM_XLEN-1:0] memData,
  output logic                 branchTaken,
  output flags_t               flags
);

  logic                 validE, aluSrcImmE, regWriteE, memWriteE, memToRegE, branchE;
  aluOp_e               aluOpE;
  logic [1:0]           flagWriteE;
  logic [3:0]           condE, rdE, rdM;
  logic [`ARM_XLEN-1:0] srcAE, srcBE, storeDataE, aluResultM, storeDataM;
  logic                 validM, regWriteM, memWriteM, memToRegM;

  instrDecode i_instrDecode (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .instrValid(instrValid),
    .instr     (instr),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData),
    .validE    (validE),
    .aluOpE    (aluOpE),
    .aluSrcImmE(aluSrcImmE),
    .flagWriteE(flagWriteE),
    .regWriteE (regWriteE),
    .memWriteE (memWriteE),
    .memToRegE (memToRegE),
    .branchE   (branchE),
    .condE     (condE),
    .rdE       (rdE),
    .srcAE     (srcAE),
    .srcBE     (srcBE),
    .storeDataE(storeDataE)
  );

  aluExec i_aluExec (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .validE     (validE),
    .aluOpE     (aluOpE),
    .aluSrcImmE (aluSrcImmE),
    .flagWriteE (flagWriteE),
    .regWriteE  (regWriteE),
    .memWriteE  (memWriteE),
    .memToRegE  (memToRegE),
    .branchE    (branchE),
    .condE      (condE),
    .rdE        (rdE),
    .srcAE      (srcAE),
    .srcBE      (srcBE),
    .storeDataE (storeDataE),
    .flags      (flags),
    .branchTaken(branchTaken),
    .validM     (validM),
    .regWriteM  (regWriteM),
    .memWriteM  (memWriteM),
    .memToRegM  (memToRegM),
    .rdM        (rdM),
    .aluResultM (aluResultM),
    .storeDataM (storeDataM)
  );

  memWriteback i_memWriteback (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .validM    (validM),
    .regWriteM (regWriteM),
    .memWriteM (memWriteM),
    .memToRegM (memToRegM),
    .rdM       (rdM),
    .aluResultM(aluResultM),
    .storeDataM(storeDataM),
    .memWe     (memWe),
    .memAddr   (memAddr),
    .memData   (memData),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .wbData    (wbData)
  );

endmodule

`default_nettype wire

// ==== armLiteCore_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module armLiteCore_chk (
  input logic        clk,
  input logic        rst,
  input logic        stall,
  input logic        instrValid,
  input logic        wbValid,
  input logic [3:0]  wbReg,
  input logic [31:0] wbData,
  input logic        memWe,
  input logic [31:0] memAddr,
  input logic [31:0] memData,
  input logic        branchTaken,
  input logic [3:0]  flags
);

  logic [2:0] acceptHist;  // Accepts over the last three unstalled edges

  always_ff @(posedge clk) begin
    if (rst) begin
      acceptHist <= '0;
    end else if (!stall) begin
      acceptHist <= {acceptHist[1:0], instrValid};
    end
  end

  wbHasSource: assert property (@(posedge clk) disable iff (rst)
    wbValid |-> acceptHist[2])
    else $error("Writeback without an instruction accepted three cycles earlier");

  quietAfterReset: assert property (@(posedge clk) rst |=> (!memWe && !wbValid))
    else $error("Write strobe high in the cycle after reset");

  branchOnePulse: assert property (@(posedge clk) disable iff (rst)
    branchTaken |=> !branchTaken)
    else $error("Branch pulse longer than one cycle");

  holdOnStall: assert property (@(posedge clk) disable iff (rst)
    stall |=> ($stable(wbValid) && $stable(wbReg) && $stable(wbData) && $stable(memWe) &&
               $stable(memAddr) && $stable(memData) && $stable(flags)))
    else $error("Outputs changed during a stall");

endmodule

`default_nettype wire

// ==== tb_armLiteCore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "armLite_macros.svh"

module tb_armLiteCore import armLitePkg::*; ;

  localparam int FieldsPerLine = 10;
  localparam int MaxLines      = 48;
  localparam int DrainLimit    = 20;
  localparam int WatchdogLimit = 4000;

  typedef struct packed {
    logic [7:0]  age;       // Unstalled cycles since acceptance
    logic [3:0]  kind;      // 0 none, 1 writeback, 2 store, 3 branch
    logic        chkFlags;
    logic [3:0]  flags;
    logic [3:0]  rd;
    logic [31:0] valA;
    logic [31:0] valB;
  } pendEvent_t;

  logic                 clk, rst, stall, instrValid;
  armInstr_u            instr;
  logic                 wbValid, memWe, branchTaken;
  logic [3:0]           wbReg;
  logic [`ARM_XLEN-1:0] wbData, memAddr, memData;
  flags_t               flags;

  logic [31:0] golden [FieldsPerLine*MaxLines];
  pendEvent_t  pending [$];
  int          errors;
  int          checks;

  armLiteCore i_armLiteCore (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .instrValid (instrValid),
    .instr      (instr),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .memWe      (memWe),
    .memAddr    (memAddr),
    .memData    (memData),
    .branchTaken(branchTaken),
    .flags      (flags)
  );

  bind armLiteCore armLiteCore_chk i_chk (
    .clk(clk), .rst(rst), .stall(stall), .instrValid(instrValid),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .memWe(memWe),
    .memAddr(memAddr), .memData(memData), .branchTaken(branchTaken), .flags(flags)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // Ages the pending events and compares the outputs of one unstalled cycle
  task automatic checkCycle(input pendEvent_t evt);
    logic        expWb, expMem, expBr;
    logic [3:0]  expReg;
    logic [31:0] expWbData, expAddr, expData;
    pendEvent_t  e;
    if (stall) return;
    expWb     = 1'b0;
    expMem    = 1'b0;
    expBr     = 1'b0;
    expReg    = '0;
    expWbData = '0;
    expAddr   = '0;
    expData   = '0;
    foreach (pending[i]) pending[i].age = pending[i].age + 8'd1;
    foreach (pending[i]) begin
      e = pending[i];
      if (e.age == 1 && e.kind == 4'd3) expBr = 1'b1;
      if (e.age == 2 && e.kind == 4'd2) begin
        expMem  = 1'b1;
        expAddr = e.valA;
        expData = e.valB;
      end
      if (e.age == 2 && e.chkFlags) checkWord("flags", 32'(flags), 32'(e.flags));
      if (e.age == 3 && e.kind == 4'd1) begin
        expWb     = 1'b1;
        expReg    = e.rd;
        expWbData = e.valA;
      end
    end
    while (pending.size() > 0 && pending[0].age >= 3) pending.pop_front();
    if (instrValid) pending.push_back(evt);
    checkWord("wbValid", 32'(wbValid), 32'(expWb));
    checkWord("memWe", 32'(memWe), 32'(expMem));
    checkWord("branchTaken", 32'(branchTaken), 32'(expBr));
    if (expWb) begin
      checkWord("wbReg", 32'(wbReg), 32'(expReg));
      checkWord("wbData", wbData, expWbData);
    end
    if (expMem) begin
      checkWord("memAddr", memAddr, expAddr);
      checkWord("memData", memData, expData);
    end
  endtask

  task automatic driveCycle(input logic stallV, input logic validV, input logic [31:0] instrV,
                            input pendEvent_t evt);
    @(posedge clk);
    stall      <= stallV;
    instrValid <= validV;
    instr      <= instrV;
    @(negedge clk);
    checkCycle(evt);
  endtask

  task automatic waitDrain();
    int         count;
    pendEvent_t idleEvt;
    count   = 0;
    idleEvt = '0;
    while (pending.size() > 0 && count < DrainLimit) begin
      driveCycle(1'b0, 1'b0, '0, idleEvt);
      count++;
    end
    if (pending.size() > 0) begin
      $display("Timeout: pending events did not complete");
      errors++;
    end
  endtask

  initial begin
    int         line;
    int         base;
    pendEvent_t evt;
    pendEvent_t idleEvt;
    rst        = 1'b1;
    stall      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    errors     = 0;
    checks     = 0;
    idleEvt    = '0;
    for (int i = 0; i < FieldsPerLine*MaxLines; i++) golden[i] = '1;
    $readmemh("armLite_golden.txt", golden);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    line = 0;
    while (line < MaxLines && golden[line*FieldsPerLine] <= 1) begin  // E marks the end
      base         = line * FieldsPerLine;
      evt.age      = '0;
      evt.kind     = golden[base+4][3:0];
      evt.chkFlags = golden[base+5][0];
      evt.flags    = golden[base+6][3:0];
      evt.rd       = golden[base+7][3:0];
      evt.valA     = golden[base+8];
      evt.valB     = golden[base+9];
      driveCycle(golden[base][0], golden[base+1][0], golden[base+3], evt);
      for (int k = 0; k < golden[base+2]; k++) driveCycle(1'b0, 1'b0, '0, idleEvt);
      line++;
    end
    waitDrain();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    for (int c = 0; c < WatchdogLimit; c++) @(posedge clk);
    $display("Timeout: simulation did not reach its end");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== armLite_golden.txt ====
// stall valid idle instr kind chkFlags flags rd valA valB
// kind 0 none, 1 writeback rd=valA, 2 store addr=valA data=valB, 3 branch; stall E ends
0 1 3 E3A01005 1 0 0 1 00000005 00000000
0 1 3 E3A0200C 1 0 0 2 0000000C 00000000
0 1 3 E0813002 1 0 0 3 00000011 00000000
0 1 3 E2424003 1 0 0 4 00000009 00000000
0 1 3 E0015002 1 0 0 5 00000004 00000000
0 1 3 E3816030 1 0 0 6 00000035 00000000
0 1 3 E0217002 1 0 0 7 00000009 00000000
0 1 3 E3A0843F 1 0 0 8 3F000000 00000000
0 1 3 E0519002 1 1 8 9 FFFFFFF9 00000000
0 1 3 E281A001 1 1 8 A 00000006 00000000
0 1 3 E0C2C001 1 1 8 C 00000006 00000000
0 1 3 E3510005 0 1 6 0 00000000 00000000
0 1 3 E0A1B002 1 1 6 B 00000012 00000000
0 1 3 13A0D007 0 1 6 0 00000000 00000000
0 1 3 13510001 0 1 6 0 00000000 00000000
0 1 3 03A0D007 1 0 0 D 00000007 00000000
0 1 3 E5823004 2 0 0 0 00000010 00000011
0 1 3 E591E00B 1 0 0 E 00000011 00000000
0 1 3 15801000 0 0 0 0 00000000 00000000
0 1 3 EA000000 3 0 0 0 00000000 00000000
0 1 3 1A000000 0 0 0 0 00000000 00000000
0 1 3 0A000010 3 0 0 0 00000000 00000000
0 1 0 E2812020 1 0 0 2 00000025 00000000
0 1 0 E5806008 2 0 0 0 00000008 00000035
1 0 0 00000000 0 0 0 0 00000000 00000000
1 0 3 00000000 0 0 0 0 00000000 00000000
0 1 3 E5907008 1 0 0 7 00000035 00000000
E 0 0 00000000 0 0 0 0 00000000 00000000

// ==== filelist.f ====
+incdir+.
armLitePkg.sv
condUnit.sv
instrDecode.sv
aluExec.sv
memWriteback.sv
armLiteCore.sv
armLiteCore_chk.sv
tb_armLiteCore.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator; the log decides pass or fail
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal -f filelist.f \
  --top-module tb_armLiteCore -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log && exit 0 || exit 1
